//--- hw/frame_classifier.sv
`timescale 1ns/10ps
`include "tracker_defines.svh"

module frame_classifier (
    input  logic                       clk,
    input  logic                       rst_n,
    input  tracker_pkg::class_pix_t    cpix,
    output tracker_pkg::frame_result_t result
);
    import tracker_pkg::*;

    localparam logic [17:0] THRESHOLD = 18'(`ORANGE_THRESHOLD);

    logic [17:0] cnt_left;
    logic [17:0] cnt_center;
    logic [17:0] cnt_right;
    logic [17:0] cnt_total;
    logic [17:0] nxt_left;
    logic [17:0] nxt_center;
    logic [17:0] nxt_right;
    logic [17:0] nxt_total;

    logic        hit;
    logic        in_left;
    logic        in_right;
    logic        in_center;
    logic        frame_last;
    dir_t        frame_dir;

    logic        res_valid;
    logic        res_detected;
    dir_t        res_dir;
    logic [17:0] res_count;

    assign frame_last = cpix.valid && cpix.frame_end;

    // Counts including the current pixel, so the last pixel of a frame is not lost
    always_comb begin
        hit        = cpix.valid && cpix.orange;
        in_left    = (cpix.col < 9'(`LEFT_END));
        in_right   = (cpix.col >= 9'(`RIGHT_START));
        in_center  = !in_left && !in_right;
        nxt_left   = cnt_left + 18'(hit && in_left);
        nxt_center = cnt_center + 18'(hit && in_center);
        nxt_right  = cnt_right + 18'(hit && in_right);
        nxt_total  = cnt_total + 18'(hit);
    end

    // Band priority, right first
    always_comb begin
        if (nxt_right > nxt_left) begin
            frame_dir = DIR_RIGHT;
        end else if ((nxt_center > nxt_left) && (nxt_center > nxt_right)) begin
            frame_dir = DIR_CENTER;
        end else if (nxt_left > nxt_right) begin
            frame_dir = DIR_LEFT;
        end else begin
            frame_dir = DIR_NONE;   // Tie, steering keeps its last value
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_left   <= '0;
            cnt_center <= '0;
            cnt_right  <= '0;
            cnt_total  <= '0;
            res_valid  <= 1'b0;
        end else begin
            res_valid <= frame_last;
            if (frame_last) begin
                cnt_left   <= '0;
                cnt_center <= '0;
                cnt_right  <= '0;
                cnt_total  <= '0;
            end else begin
                cnt_left   <= nxt_left;
                cnt_center <= nxt_center;
                cnt_right  <= nxt_right;
                cnt_total  <= nxt_total;
            end
        end
    end

    // Frame verdict, sampled once per frame
    always_ff @(posedge clk) begin
        if (frame_last) begin
            res_detected <= (nxt_total > THRESHOLD);
            res_dir      <= frame_dir;
            res_count    <= nxt_total;
        end
    end

    assign result = '{valid:    res_valid,
                      detected: res_detected,
                      dir:      res_dir,
                      count:    res_count};

    a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid |=> !result.valid);

endmodule

//--- hw/orange_detect.sv
`timescale 1ns/10ps
`include "tracker_defines.svh"

module orange_detect (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tracker_pkg::pixel_t     pix,
    output tracker_pkg::class_pix_t cpix
);
    logic       orange_hit;
    logic       valid_q;
    logic       orange_q;
    logic [8:0] col_q;
    logic       line_end_q;
    logic       frame_end_q;

    // Colour window test on the raw channels
    assign orange_hit = (pix.color.r >= 4'(`R_MIN)) &&
                        (pix.color.g >= 4'(`G_MIN)) &&
                        (pix.color.g <= 4'(`G_MAX)) &&
                        (pix.color.b <= 4'(`B_MAX));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pix.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            orange_q    <= orange_hit;
            col_q       <= pix.col;        // Position rides along for banding
            line_end_q  <= pix.line_end;
            frame_end_q <= pix.frame_end;
        end
    end

    assign cpix = '{valid:     valid_q,
                    orange:    orange_q,
                    col:       col_q,
                    line_end:  line_end_q,
                    frame_end: frame_end_q};

endmodule

//--- hw/orange_tracker_top.sv
`timescale 1ns/10ps

module orange_tracker_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        cam_data,
    input  logic              byte_valid,
    input  logic              href,
    output logic              orange_detected,
    output tracker_pkg::dir_t direction,
    output logic [17:0]       orange_count,
    output logic              frame_done
);
    import tracker_pkg::*;

    pixel_t        pix;      // Assembled pixels with position
    class_pix_t    cpix;     // Orange flag per pixel
    frame_result_t result;   // One verdict per frame

    pixel_capture u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .cam_data   (cam_data),
        .byte_valid (byte_valid),
        .href       (href),
        .pix        (pix)
    );

    orange_detect u_detect (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix),
        .cpix  (cpix)
    );

    frame_classifier u_classify (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpix   (cpix),
        .result (result)
    );

    steer_output u_steer (
        .clk             (clk),
        .rst_n           (rst_n),
        .result          (result),
        .orange_detected (orange_detected),
        .direction       (direction),
        .orange_count    (orange_count),
        .frame_done      (frame_done)
    );

endmodule

//--- hw/pixel_capture.sv
`timescale 1ns/10ps
`include "tracker_defines.svh"

module pixel_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          cam_data,
    input  logic                byte_valid,
    input  logic                href,
    output tracker_pkg::pixel_t pix
);
    import tracker_pkg::*;

    localparam logic [8:0] LAST_COL = 9'(`FRAME_W - 1);
    localparam logic [7:0] LAST_ROW = 8'(`FRAME_H - 1);

    cap_state_t state;
    logic [8:0] col;
    logic [7:0] row;
    logic [3:0] red_hold;      // Red nibble held between the two bytes

    logic       out_valid;
    logic [3:0] out_r;
    logic [3:0] out_g;
    logic [3:0] out_b;
    logic [8:0] out_col;
    logic       out_line_end;
    logic       out_frame_end;

    logic       first_byte;
    logic       second_byte;
    logic       row_done;

    assign first_byte  = href && byte_valid && (state == CAP_HIGH);
    assign second_byte = href && byte_valid && (state == CAP_LOW);
    assign row_done    = (col == LAST_COL);

    // Byte pairing FSM with column and row tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_HIGH;
            col       <= '0;
            row       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= second_byte;
            if (!href) begin
                state <= CAP_HIGH;             // Row gap restarts the pairing
                col   <= '0;
            end else if (first_byte) begin
                state <= CAP_LOW;
            end else if (second_byte) begin
                state <= CAP_HIGH;
                if (row_done) begin
                    col <= '0;
                    row <= (row == LAST_ROW) ? '0 : row + 8'd1;
                end else begin
                    col <= col + 9'd1;
                end
            end
        end
    end

    // Pixel data path
    always_ff @(posedge clk) begin
        if (first_byte) begin
            red_hold <= cam_data[3:0];
        end
        if (second_byte) begin
            out_r         <= red_hold;
            out_g         <= cam_data[7:4];
            out_b         <= cam_data[3:0];
            out_col       <= col;
            out_line_end  <= row_done;
            out_frame_end <= row_done && (row == LAST_ROW);
        end
    end

    assign pix = '{valid:     out_valid,
                   color:     '{r: out_r, g: out_g, b: out_b},
                   col:       out_col,
                   line_end:  out_line_end,
                   frame_end: out_frame_end};

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        pix.valid |-> (pix.col <= LAST_COL));

endmodule

//--- hw/steer_output.sv
`timescale 1ns/10ps
`include "tracker_defines.svh"

module steer_output (
    input  logic                       clk,
    input  logic                       rst_n,
    input  tracker_pkg::frame_result_t result,
    output logic                       orange_detected,
    output tracker_pkg::dir_t          direction,
    output logic [17:0]                orange_count,
    output logic                       frame_done
);
    import tracker_pkg::*;

    localparam int                MISS_W     = $clog2(`LOST_FRAMES + 1);
    localparam logic [MISS_W-1:0] MISS_LIMIT = MISS_W'(`LOST_FRAMES);

    logic [MISS_W-1:0] miss_cnt;
    logic [MISS_W-1:0] miss_nxt;

    // Miss count saturates once steering has been dropped
    assign miss_nxt = (miss_cnt == MISS_LIMIT) ? miss_cnt : miss_cnt + MISS_W'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            orange_detected <= 1'b0;
            direction       <= DIR_NONE;
            orange_count    <= '0;
            frame_done      <= 1'b0;
            miss_cnt        <= '0;
        end else begin
            frame_done <= result.valid;
            if (result.valid) begin
                orange_detected <= result.detected;
                orange_count    <= result.count;
                if (result.detected) begin
                    miss_cnt <= '0;
                    if (result.dir != DIR_NONE) begin
                        direction <= result.dir;
                    end
                end else begin
                    miss_cnt <= miss_nxt;
                    if (miss_nxt == MISS_LIMIT) begin
                        direction <= DIR_NONE;   // Target lost
                    end
                end
            end
        end
    end

endmodule

//--- hw/tracker_pkg.sv
package tracker_pkg;

    // Steering codes
    typedef enum logic [2:0] {
        DIR_NONE   = 3'd0,
        DIR_LEFT   = 3'd1,
        DIR_RIGHT  = 3'd2,
        DIR_CENTER = 3'd3
    } dir_t;

    // Which byte of a pixel comes next
    typedef enum logic {
        CAP_HIGH = 1'b0,
        CAP_LOW  = 1'b1
    } cap_state_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    typedef struct packed {
        logic       valid;
        rgb444_t    color;
        logic [8:0] col;
        logic       line_end;   // Last pixel of a row
        logic       frame_end;  // Last pixel of the last row
    } pixel_t;

    typedef struct packed {
        logic       valid;
        logic       orange;
        logic [8:0] col;
        logic       line_end;
        logic       frame_end;
    } class_pix_t;

    typedef struct packed {
        logic        valid;
        logic        detected;
        dir_t        dir;
        logic [17:0] count;
    } frame_result_t;

endpackage

//--- include/tracker_defines.svh
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// Sensor frame geometry in pixels
`define FRAME_W 320
`define FRAME_H 240

// Band edges by column
`define LEFT_END    50   // First centre column
`define RIGHT_START 290  // First right column

// Orange pixels needed for a detection, 2% of the frame
`define ORANGE_THRESHOLD ((`FRAME_W * `FRAME_H) / 50)

// Orange colour window on 4-bit channels
`define R_MIN 12
`define G_MIN 4
`define G_MAX 10
`define B_MAX 4

// Consecutive empty frames before steering falls back to none
`define LOST_FRAMES 3

`endif

//--- tb.f
+incdir+include
hw/tracker_pkg.sv
hw/pixel_capture.sv
hw/orange_detect.sv
hw/frame_classifier.sv
hw/steer_output.sv
hw/orange_tracker_top.sv
verif/tb_clk_gen.sv
verif/tb_orange_tracker.sv

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset released on a rising edge after a fixed number of cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/tb_orange_tracker.sv
`timescale 1ns/10ps
`include "tracker_defines.svh"

module tb_orange_tracker;
    import tracker_pkg::*;

    localparam int DONE_LATENCY  = 4;    // Last byte to frame_done
    localparam int DONE_TIMEOUT  = 50;
    localparam int RESET_TIMEOUT = 100;

    // Frame colour patterns
    localparam int PAT_EMPTY  = 0;
    localparam int PAT_RIGHT  = 1;
    localparam int PAT_CENTER = 2;
    localparam int PAT_LEFT   = 3;
    localparam int PAT_EXACT  = 4;
    localparam int PAT_ABOVE  = 5;
    localparam int PAT_TIE    = 6;
    localparam int PAT_RANDOM = 7;

    localparam rgb444_t ORANGE = '{r: 4'hF, g: 4'h7, b: 4'h2};

    logic        clk;
    logic        rst_n;
    logic [7:0]  cam_data;
    logic        byte_valid;
    logic        href;
    logic        orange_detected;
    dir_t        direction;
    logic [17:0] orange_count;
    logic        frame_done;

    logic [31:0] lcg_state;

    // Reference model state
    int   m_left;
    int   m_center;
    int   m_right;
    int   m_total;
    int   m_last_count;
    int   m_miss;
    logic m_detected;
    dir_t m_dir;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    orange_tracker_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cam_data        (cam_data),
        .byte_valid      (byte_valid),
        .href            (href),
        .orange_detected (orange_detected),
        .direction       (direction),
        .orange_count    (orange_count),
        .frame_done      (frame_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Colours that miss the orange window by one step on each limit
    function automatic rgb444_t near_miss(input int sel);
        case (sel % 4)
            0:       return '{r: 4'hB, g: 4'h7, b: 4'h2};   // Red too low
            1:       return '{r: 4'hF, g: 4'h3, b: 4'h2};   // Green too low
            2:       return '{r: 4'hF, g: 4'hB, b: 4'h2};   // Green too high
            default: return '{r: 4'hF, g: 4'h7, b: 4'h5};   // Blue too high
        endcase
    endfunction

    function automatic rgb444_t color_of(input int pat, input int col, input int row);
        logic in_block;
        logic in_exact;
        in_exact = (col >= 100) && (col < 196) && (row < 16);   // 96 x 16 pixels
        case (pat)
            PAT_RIGHT:  in_block = (col >= `RIGHT_START) && (row < 100);
            PAT_CENTER: in_block = (col >= 100) && (col < 200) && (row < 30);
            PAT_LEFT:   in_block = (col < `LEFT_END) && (row < 60);
            PAT_EXACT:  in_block = in_exact;
            PAT_ABOVE:  in_block = in_exact || ((col == 200) && (row == 16));
            PAT_TIE:    in_block = ((col < 30) || (col >= `RIGHT_START)) && (row < 60);
            default:    in_block = 1'b0;
        endcase
        return in_block ? ORANGE : near_miss(col + row);
    endfunction

    function automatic logic is_orange(input rgb444_t c);
        return (c.r >= `R_MIN) && (c.g >= `G_MIN) && (c.g <= `G_MAX) && (c.b <= `B_MAX);
    endfunction

    function automatic dir_t band_dir(input int l, input int c, input int r);
        if (r > l) return DIR_RIGHT;
        if ((c > l) && (c > r)) return DIR_CENTER;
        if (l > r) return DIR_LEFT;
        return DIR_NONE;
    endfunction

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_dir(input dir_t got, input dir_t exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input logic [17:0] got, input logic [17:0] exp,
                               input string name);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic model_pixel(input rgb444_t px, input int col);
        if (is_orange(px)) begin
            m_total++;
            if (col < `LEFT_END) m_left++;
            else if (col >= `RIGHT_START) m_right++;
            else m_center++;
        end
    endtask

    // Frame verdict and held steering as seen at the outputs
    task automatic model_frame_end();
        dir_t fd;
        fd = band_dir(m_left, m_center, m_right);
        m_detected = (m_total > `ORANGE_THRESHOLD);
        if (m_detected) begin
            m_miss = 0;
            if (fd != DIR_NONE) m_dir = fd;
        end else begin
            if (m_miss < `LOST_FRAMES) m_miss++;
            if (m_miss == `LOST_FRAMES) m_dir = DIR_NONE;
        end
        m_last_count = m_total;
        m_left = 0;
        m_center = 0;
        m_right = 0;
        m_total = 0;
    endtask

    task automatic drive_frame(input int pat);
        rgb444_t px;
        for (int row = 0; row < `FRAME_H; row++) begin
            for (int col = 0; col < `FRAME_W; col++) begin
                if (pat == PAT_RANDOM) begin
                    lcg_state = lcg_next(lcg_state);
                    px = lcg_state[27:16];
                end else begin
                    px = color_of(pat, col, row);
                end
                model_pixel(px, col);
                @(posedge clk);
                href       <= 1'b1;
                byte_valid <= 1'b1;
                cam_data   <= {4'h5, px.r};   // High nibble is ignored
                @(posedge clk);
                cam_data   <= {px.g, px.b};
            end
            @(posedge clk);                   // Two-cycle row gap
            href       <= 1'b0;
            byte_valid <= 1'b0;
            cam_data   <= '0;
            @(posedge clk);
        end
    endtask

    task automatic wait_frame_done();
        int   cycles;
        logic seen;
        cycles = 2;   // Row gap already spent after the last byte
        seen = 1'b0;
        while (!seen && (cycles < DONE_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = frame_done;
        end
        if (!seen) begin
            $display("Timeout: frame_done never pulsed after the last pixel of a frame");
            stop_run();
        end
        if (cycles != DONE_LATENCY) begin
            $display("frame_done came %0d cycles after the last byte, expected %0d",
                     cycles, DONE_LATENCY);
            stop_run();
        end
    endtask

    task automatic run_frame(input int pat);
        drive_frame(pat);
        wait_frame_done();
        model_frame_end();
        check_count(orange_count, 18'(m_last_count), "orange_count");
        check_bit(orange_detected, m_detected, "orange_detected");
        check_dir(direction, m_dir, "direction");
        @(posedge clk);
        @(negedge clk);
        check_bit(frame_done, 1'b0, "frame_done");   // One-cycle pulse
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while ((rst_n !== 1'b1) && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            stop_run();
        end
        @(negedge clk);
    endtask

    task automatic test_reset_and_empty();
        check_bit(orange_detected, 1'b0, "orange_detected");
        check_dir(direction, DIR_NONE, "direction");
        check_count(orange_count, 18'd0, "orange_count");
        check_bit(frame_done, 1'b0, "frame_done");
        run_frame(PAT_EMPTY);
        check_count(orange_count, 18'd0, "orange_count");
        check_bit(orange_detected, 1'b0, "orange_detected");
    endtask

    task automatic test_right_block();
        run_frame(PAT_RIGHT);
        check_bit(orange_detected, 1'b1, "orange_detected");
        check_dir(direction, DIR_RIGHT, "direction");
        check_count(orange_count, 18'd3000, "orange_count");   // 30 columns x 100 rows
    endtask

    task automatic test_center_and_left();
        run_frame(PAT_CENTER);
        check_dir(direction, DIR_CENTER, "direction");
        run_frame(PAT_LEFT);
        check_dir(direction, DIR_LEFT, "direction");
    endtask

    task automatic test_threshold_edge();
        run_frame(PAT_EXACT);
        check_bit(orange_detected, 1'b0, "orange_detected");
        check_count(orange_count, 18'(`ORANGE_THRESHOLD), "orange_count");
        run_frame(PAT_ABOVE);
        check_bit(orange_detected, 1'b1, "orange_detected");
        check_count(orange_count, 18'(`ORANGE_THRESHOLD + 1), "orange_count");
    endtask

    task automatic test_lost_frames();
        run_frame(PAT_RIGHT);
        for (int i = 1; i <= `LOST_FRAMES; i++) begin
            run_frame(PAT_EMPTY);
            check_dir(direction, (i < `LOST_FRAMES) ? DIR_RIGHT : DIR_NONE, "direction");
        end
    endtask

    task automatic test_random_and_tie();
        dir_t held;
        run_frame(PAT_RANDOM);
        held = m_dir;
        run_frame(PAT_TIE);                  // Equal left and right bands
        check_bit(orange_detected, 1'b1, "orange_detected");
        check_dir(direction, held, "direction");
        check_count(orange_count, 18'd3600, "orange_count");
    endtask

    initial begin
        cam_data     = '0;
        byte_valid   = 1'b0;
        href         = 1'b0;
        lcg_state    = 32'd57;
        m_left       = 0;
        m_center     = 0;
        m_right      = 0;
        m_total      = 0;
        m_last_count = 0;
        m_miss       = 0;
        m_detected   = 1'b0;
        m_dir        = DIR_NONE;

        wait_reset_release();
        test_reset_and_empty();
        test_right_block();
        test_center_and_left();
        test_threshold_edge();
        test_lost_frames();
        test_random_and_tie();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
